//--- hw/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// lanes renamed per cycle
`define RN_WIDTH 3

// register file sizes
`define RN_NUM_AREG 32
`define RN_NUM_PREG 64

// every physical register not holding an architectural mapping
`define RN_FL_DEPTH (`RN_NUM_PREG - `RN_NUM_AREG)

`endif

//--- hw/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    // register names
    typedef logic [$clog2(`RN_NUM_AREG)-1:0] areg_t;
    typedef logic [$clog2(`RN_NUM_PREG)-1:0] preg_t;

    // free list slot index and occupancy
    typedef logic [$clog2(`RN_FL_DEPTH)-1:0] fl_ptr_t;
    typedef logic [$clog2(`RN_FL_DEPTH+1)-1:0] fl_count_t;

    typedef logic [`RN_WIDTH-1:0] lane_mask_t;

    typedef enum logic {
        REC_RUN,
        REC_RECOVER
    } rec_state_t;

endpackage

//--- hw/free_list_if.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

interface free_list_if import rename_pkg::*; ();

    // allocation side
    lane_mask_t                alloc_mask;
    preg_t [`RN_WIDTH-1:0]     alloc_preg;

    // release side
    lane_mask_t                free_mask;
    preg_t [`RN_WIDTH-1:0]     free_preg;

    fl_count_t                 free_count;
    logic                      refill;

    modport ctrl (
        output alloc_mask,
        output free_mask,
        output free_preg,
        output refill,
        input  alloc_preg,
        input  free_count
    );

    modport list (
        input  alloc_mask,
        input  free_mask,
        input  free_preg,
        input  refill,
        output alloc_preg,
        output free_count
    );

endinterface

//--- hw/free_list.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module free_list import rename_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    free_list_if.list   fl
);

    localparam int CW = $clog2(`RN_WIDTH + 1);

    preg_t [`RN_FL_DEPTH-1:0] slots;

    // head is the oldest free entry, tail the newest one
    fl_ptr_t   head;
    fl_ptr_t   tail;
    fl_ptr_t   tail_next;
    fl_count_t count;

    logic [`RN_WIDTH-1:0][CW-1:0] pop_off;
    logic [`RN_WIDTH-1:0][CW-1:0] push_off;
    logic [CW-1:0]                pop_num;
    logic [CW-1:0]                push_num;

    // ------------------------------
    // lane offsets
    // ------------------------------

    // each set lane takes the slot after the one used by the lane below it
    always_comb begin
        pop_num  = '0;
        push_num = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            pop_off[k]  = pop_num;
            push_off[k] = push_num;
            pop_num     = pop_num + CW'(fl.alloc_mask[k]);
            push_num    = push_num + CW'(fl.free_mask[k]);
        end
    end

    assign tail_next = fl_ptr_t'(tail + fl_ptr_t'(push_num));

    // ------------------------------
    // allocation read
    // ------------------------------

    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            fl.alloc_preg[k] = slots[fl_ptr_t'(head + fl_ptr_t'(pop_off[k]))];
        end
    end

    assign fl.free_count = count;

    // ------------------------------
    // state update
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= fl_ptr_t'(`RN_FL_DEPTH - 1);
            count <= fl_count_t'(`RN_FL_DEPTH);
            for (int i = 0; i < `RN_FL_DEPTH; i++) begin
                slots[i] <= preg_t'(`RN_NUM_AREG + i);
            end
        end else begin
            // released registers land behind the current tail
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (fl.free_mask[k]) begin
                    slots[fl_ptr_t'(tail + fl_ptr_t'(push_off[k]) + fl_ptr_t'(1))]
                        <= fl.free_preg[k];
                end
            end
            tail <= tail_next;

            if (fl.refill) begin
                // squash returns every in-flight register, so the whole ring is free
                head  <= fl_ptr_t'(tail_next + fl_ptr_t'(1));
                count <= fl_count_t'(`RN_FL_DEPTH);
            end else begin
                head  <= fl_ptr_t'(head + fl_ptr_t'(pop_num));
                count <= fl_count_t'(count - fl_count_t'(pop_num) + fl_count_t'(push_num));
            end
        end
    end

endmodule

//--- hw/spec_map_table.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module spec_map_table import rename_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    // lookup
    input  areg_t [`RN_WIDTH-1:0][1:0]    src_areg,
    output preg_t [`RN_WIDTH-1:0][1:0]    src_preg,
    // new destination mappings
    input  areg_t [`RN_WIDTH-1:0]         dst_areg,
    input  lane_mask_t                    write_mask,
    input  preg_t [`RN_WIDTH-1:0]         dst_preg,
    // recovery copy from the committed map
    input  logic                          reload,
    input  preg_t [`RN_NUM_AREG-1:0]      arch_map
);

    preg_t [`RN_NUM_AREG-1:0] map;

    // ------------------------------
    // source lookup with bypass
    // ------------------------------

    // an earlier lane writing the same name overrides the table,
    // the highest such lane being the last to match
    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            for (int s = 0; s < 2; s++) begin
                src_preg[k][s] = map[src_areg[k][s]];
                for (int l = 0; l < k; l++) begin
                    if (write_mask[l] && (dst_areg[l] == src_areg[k][s])) begin
                        src_preg[k][s] = dst_preg[l];
                    end
                end
            end
        end
    end

    // ------------------------------
    // table update
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RN_NUM_AREG; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (reload) begin
            map <= arch_map;
        end else begin
            // lane order, so a later lane wins on the same name
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (write_mask[k]) begin
                    map[dst_areg[k]] <= dst_preg[k];
                end
            end
        end
    end

endmodule

//--- hw/retire_map_table.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module retire_map_table import rename_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  lane_mask_t                    retire_mask,
    input  areg_t [`RN_WIDTH-1:0]         retire_areg,
    input  preg_t [`RN_WIDTH-1:0]         retire_preg,
    output preg_t [`RN_WIDTH-1:0]         displaced_preg,
    output preg_t [`RN_NUM_AREG-1:0]      arch_map
);

    preg_t [`RN_NUM_AREG-1:0] map;

    // mapping each lane overwrites
    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            displaced_preg[k] = map[retire_areg[k]];
            for (int l = 0; l < k; l++) begin
                if (retire_mask[l] && (retire_areg[l] == retire_areg[k])) begin
                    displaced_preg[k] = retire_preg[l];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RN_NUM_AREG; i++) begin
                map[i] <= preg_t'(i);
            end
        end else begin
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (retire_mask[k]) begin
                    map[retire_areg[k]] <= retire_preg[k];
                end
            end
        end
    end

    assign arch_map = map;

endmodule

//--- hw/rename_ctrl.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_ctrl import rename_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  lane_mask_t                    rename_valid,
    free_list_if.ctrl                     fl,
    // speculative map side
    output lane_mask_t                    write_mask,
    output preg_t [`RN_WIDTH-1:0]         dst_preg,
    output logic                          reload,
    input  preg_t [`RN_WIDTH-1:0][1:0]    src_preg,
    // retirement side
    input  lane_mask_t                    retire_valid,
    output lane_mask_t                    retire_mask,
    input  preg_t [`RN_WIDTH-1:0]         displaced_preg,
    input  logic                          recover,
    // registered stage outputs
    output logic                          rename_done,
    output logic                          rename_reject,
    output lane_mask_t                    done_mask,
    output preg_t [`RN_WIDTH-1:0]         out_dst_preg,
    output preg_t [`RN_WIDTH-1:0][1:0]    out_src_preg
);

    rec_state_t state;
    rec_state_t state_next;

    logic       blocked;
    logic       accept;
    fl_count_t  lane_count;
    lane_mask_t grant;

    lane_mask_t            free_mask_q;
    preg_t [`RN_WIDTH-1:0] free_preg_q;

    // ------------------------------
    // recovery FSM
    // ------------------------------

    assign state_next = recover ? REC_RECOVER : REC_RUN;

    // nothing new enters while a squash is pending or in progress
    assign blocked = recover || (state == REC_RECOVER);
    assign reload  = (state == REC_RECOVER);

    // ------------------------------
    // group accept
    // ------------------------------

    always_comb begin
        lane_count = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            lane_count = lane_count + fl_count_t'(rename_valid[k]);
        end
    end

    // all lanes or none
    assign accept = (|rename_valid) && !blocked && (lane_count <= fl.free_count);
    assign grant  = accept ? rename_valid : '0;

    assign fl.alloc_mask = grant;
    assign write_mask    = grant;
    assign dst_preg      = fl.alloc_preg;

    // retires held off around recovery
    assign retire_mask = blocked ? '0 : retire_valid;

    assign fl.free_mask = free_mask_q;
    assign fl.free_preg = free_preg_q;
    assign fl.refill    = reload;

    // ------------------------------
    // registers
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= REC_RUN;
            rename_done   <= 1'b0;
            rename_reject <= 1'b0;
            done_mask     <= '0;
            free_mask_q   <= '0;
        end else begin
            state         <= state_next;
            rename_done   <= accept;
            rename_reject <= (|rename_valid) && !accept;
            done_mask     <= grant;
            free_mask_q   <= retire_mask;
        end
    end

    always_ff @(posedge clock) begin
        out_dst_preg <= fl.alloc_preg;
        out_src_preg <= src_preg;
        free_preg_q  <= displaced_preg;
    end

endmodule

//--- hw/rename_top.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_top import rename_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    // rename group
    input  lane_mask_t                rename_valid,
    input  areg_t [`RN_WIDTH-1:0]     rename_dst,
    input  areg_t [`RN_WIDTH-1:0]     rename_src1,
    input  areg_t [`RN_WIDTH-1:0]     rename_src2,
    // retirement
    input  lane_mask_t                retire_valid,
    input  areg_t [`RN_WIDTH-1:0]     retire_areg,
    input  preg_t [`RN_WIDTH-1:0]     retire_preg,
    input  logic                      recover,
    // results
    output logic                      rename_done,
    output logic                      rename_reject,
    output lane_mask_t                done_mask,
    output preg_t [`RN_WIDTH-1:0]     done_dst_preg,
    output preg_t [`RN_WIDTH-1:0]     done_src1_preg,
    output preg_t [`RN_WIDTH-1:0]     done_src2_preg,
    output fl_count_t                 free_count_out
);

    areg_t [`RN_WIDTH-1:0][1:0] src_areg;
    preg_t [`RN_WIDTH-1:0][1:0] src_preg;
    preg_t [`RN_WIDTH-1:0][1:0] out_src_preg;
    lane_mask_t                 write_mask;
    preg_t [`RN_WIDTH-1:0]      dst_preg;
    logic                       reload;
    lane_mask_t                 retire_mask;
    preg_t [`RN_WIDTH-1:0]      displaced_preg;
    preg_t [`RN_NUM_AREG-1:0]   arch_map;

    free_list_if i_fl_if ();

    // source pairs per lane
    for (genvar k = 0; k < `RN_WIDTH; k++) begin : g_lane
        assign src_areg[k][0]    = rename_src1[k];
        assign src_areg[k][1]    = rename_src2[k];
        assign done_src1_preg[k] = out_src_preg[k][0];
        assign done_src2_preg[k] = out_src_preg[k][1];
    end

    assign free_count_out = i_fl_if.free_count;

    rename_ctrl i_rename_ctrl (
        .clock          (clock),
        .reset          (reset),
        .rename_valid   (rename_valid),
        .fl             (i_fl_if.ctrl),
        .write_mask     (write_mask),
        .dst_preg       (dst_preg),
        .reload         (reload),
        .src_preg       (src_preg),
        .retire_valid   (retire_valid),
        .retire_mask    (retire_mask),
        .displaced_preg (displaced_preg),
        .recover        (recover),
        .rename_done    (rename_done),
        .rename_reject  (rename_reject),
        .done_mask      (done_mask),
        .out_dst_preg   (done_dst_preg),
        .out_src_preg   (out_src_preg)
    );

    free_list i_free_list (
        .clock (clock),
        .reset (reset),
        .fl    (i_fl_if.list)
    );

    spec_map_table i_spec_map_table (
        .clock      (clock),
        .reset      (reset),
        .src_areg   (src_areg),
        .src_preg   (src_preg),
        .dst_areg   (rename_dst),
        .write_mask (write_mask),
        .dst_preg   (dst_preg),
        .reload     (reload),
        .arch_map   (arch_map)
    );

    retire_map_table i_retire_map_table (
        .clock          (clock),
        .reset          (reset),
        .retire_mask    (retire_mask),
        .retire_areg    (retire_areg),
        .retire_preg    (retire_preg),
        .displaced_preg (displaced_preg),
        .arch_map       (arch_map)
    );

endmodule

//--- tests/rename_checks.svh
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

// ------------------------------
// compare tasks
// ------------------------------

task automatic check_preg(input string name, input preg_t expected, input preg_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic check_count(input string name, input fl_count_t expected,
                           input fl_count_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic check_mask(input string name, input lane_mask_t expected,
                          input lane_mask_t actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error %s: expected %b, actual %b", name, expected, actual);
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error %s: expected %b, actual %b", name, expected, actual);
    end
endtask

// ------------------------------
// stimulus helpers
// ------------------------------

function automatic areg_t rand_areg();
    return areg_t'($random(seed));
endfunction

task automatic fill_random();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        rename_dst[k]  = rand_areg();
        rename_src1[k] = rand_areg();
        rename_src2[k] = rand_areg();
    end
endtask

// names come from rename_dst and rename_src*, set by the caller
task automatic rename_group(input string name, input lane_mask_t valid);
    preg_t [`RN_WIDTH-1:0] exp_dst;
    preg_t [`RN_WIDTH-1:0] exp_src1;
    preg_t [`RN_WIDTH-1:0] exp_src2;
    logic                  accept;
    accept = ($countones(valid) <= free_q.size());
    check_count({name, " count"}, fl_count_t'(free_q.size()), free_count_out);
    if (accept) begin
        model_rename(valid, exp_dst, exp_src1, exp_src2);
    end
    rename_valid = valid;
    @(negedge clock);
    rename_valid = '0;
    check_flag({name, " done"}, accept, rename_done);
    check_flag({name, " reject"}, !accept, rename_reject);
    if (accept) begin
        check_mask({name, " mask"}, valid, done_mask);
        for (int k = 0; k < `RN_WIDTH; k++) begin
            if (valid[k]) begin
                check_preg($sformatf("%s dst%0d", name, k), exp_dst[k], done_dst_preg[k]);
                check_preg($sformatf("%s src1_%0d", name, k), exp_src1[k], done_src1_preg[k]);
                check_preg($sformatf("%s src2_%0d", name, k), exp_src2[k], done_src2_preg[k]);
            end
        end
    end
endtask

// pushes land one edge after the retire edge
task automatic retire_oldest(input string name, input int lanes);
    retire_valid = '0;
    if (flight_areg.size() < lanes) begin
        errors++;
        $display("%s: model has fewer renamed registers than lanes to retire", name);
    end
    for (int k = 0; k < lanes && flight_areg.size() > 0; k++) begin
        retire_valid[k] = 1'b1;
        retire_areg[k]  = flight_areg.pop_front();
        retire_preg[k]  = flight_preg.pop_front();
        model_retire(retire_areg[k], retire_preg[k]);
    end
    @(negedge clock);
    retire_valid = '0;
    @(negedge clock);
    check_count({name, " count"}, fl_count_t'(free_q.size()), free_count_out);
endtask

task automatic report_test(input string name, input int start);
    tests++;
    if (errors == start) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - start);
    end
endtask

// ------------------------------
// directed tests
// ------------------------------

task automatic test_reset_state();
    int    start;
    areg_t base;
    start = errors;
    base  = rand_areg();
    fill_random();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        rename_dst[k] = areg_t'(base + k);
    end
    rename_group("reset_state", '1);
    report_test("reset_state", start);
endtask

task automatic test_bypass();
    int    start;
    areg_t x;
    start = errors;
    x     = rand_areg();
    fill_random();
    // lanes 0 and 1 both write x, lanes 1 and 2 read it
    rename_dst[0]  = x;
    rename_dst[1]  = x;
    rename_dst[2]  = areg_t'(x + 1);
    rename_src1[1] = x;
    rename_src1[2] = x;
    rename_src2[2] = x;
    rename_group("bypass", '1);
    fill_random();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        rename_src1[k] = x;
        rename_src2[k] = areg_t'(x + 1);
    end
    rename_group("bypass lookup", '1);
    report_test("bypass", start);
endtask

task automatic test_exhaustion();
    int start;
    start = errors;
    while (free_q.size() >= `RN_WIDTH) begin
        fill_random();
        rename_group("exhaustion drain", '1);
    end
    fill_random();
    rename_group("exhaustion refuse", '1);
    check_count("exhaustion count after refuse", fl_count_t'(free_q.size()), free_count_out);
    report_test("exhaustion", start);
endtask

task automatic test_retire_reuse();
    int start;
    start = errors;
    // the second group wrote one name from two lanes
    for (int i = 0; i < 3; i++) begin
        retire_oldest("retire_reuse retire", `RN_WIDTH);
    end
    for (int i = 0; i < 3; i++) begin
        fill_random();
        rename_group("retire_reuse alloc", '1);
    end
    report_test("retire_reuse", start);
endtask

task automatic test_recovery();
    int start;
    start = errors;
    retire_oldest("recovery retire", `RN_WIDTH);
    retire_oldest("recovery retire", `RN_WIDTH);
    fill_random();
    rename_group("recovery rename", '1);
    fill_random();
    rename_group("recovery rename", 3'b011);
    retire_oldest("recovery partial retire", 2);
    model_recover();
    // a group arriving with the squash or during it is refused
    fill_random();
    rename_valid = '1;
    recover      = 1'b1;
    @(negedge clock);
    recover = 1'b0;
    check_flag("recovery reject at strobe", 1'b1, rename_reject);
    check_flag("recovery done at strobe", 1'b0, rename_done);
    @(negedge clock);
    rename_valid = '0;
    check_flag("recovery reject in squash", 1'b1, rename_reject);
    check_flag("recovery done in squash", 1'b0, rename_done);
    check_count("recovery count", fl_count_t'(`RN_FL_DEPTH), free_count_out);
    fill_random();
    rename_group("recovery after", '1);
    report_test("recovery", start);
endtask

`endif

//--- tests/rename_tb.sv
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_tb import rename_pkg::*; ();

    // the five tests need well under 100 cycles
    localparam int MAX_CYCLES = 400;

    logic                  clock;
    logic                  reset;
    lane_mask_t            rename_valid;
    areg_t [`RN_WIDTH-1:0] rename_dst;
    areg_t [`RN_WIDTH-1:0] rename_src1;
    areg_t [`RN_WIDTH-1:0] rename_src2;
    lane_mask_t            retire_valid;
    areg_t [`RN_WIDTH-1:0] retire_areg;
    preg_t [`RN_WIDTH-1:0] retire_preg;
    logic                  recover;
    logic                  rename_done;
    logic                  rename_reject;
    lane_mask_t            done_mask;
    preg_t [`RN_WIDTH-1:0] done_dst_preg;
    preg_t [`RN_WIDTH-1:0] done_src1_preg;
    preg_t [`RN_WIDTH-1:0] done_src2_preg;
    fl_count_t             free_count_out;

    // reference model
    preg_t spec_map [`RN_NUM_AREG];
    preg_t ret_map [`RN_NUM_AREG];
    preg_t free_q [$];
    // renamed but not yet retired, oldest first
    areg_t flight_areg [$];
    preg_t flight_preg [$];

    int seed = 351;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    rename_top i_rename_top (
        .clock          (clock),
        .reset          (reset),
        .rename_valid   (rename_valid),
        .rename_dst     (rename_dst),
        .rename_src1    (rename_src1),
        .rename_src2    (rename_src2),
        .retire_valid   (retire_valid),
        .retire_areg    (retire_areg),
        .retire_preg    (retire_preg),
        .recover        (recover),
        .rename_done    (rename_done),
        .rename_reject  (rename_reject),
        .done_mask      (done_mask),
        .done_dst_preg  (done_dst_preg),
        .done_src1_preg (done_src1_preg),
        .done_src2_preg (done_src2_preg),
        .free_count_out (free_count_out)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // model updates
    // ------------------------------

    task automatic model_reset();
        free_q.delete();
        for (int i = 0; i < `RN_NUM_AREG; i++) begin
            spec_map[i] = preg_t'(i);
            ret_map[i]  = preg_t'(i);
        end
        for (int i = 0; i < `RN_FL_DEPTH; i++) begin
            free_q.push_back(preg_t'(`RN_NUM_AREG + i));
        end
    endtask

    // lanes in order, so each lane sees the writes of the lanes before it
    task automatic model_rename(input lane_mask_t valid, output preg_t [`RN_WIDTH-1:0] dst,
                                output preg_t [`RN_WIDTH-1:0] src1,
                                output preg_t [`RN_WIDTH-1:0] src2);
        dst  = '0;
        src1 = '0;
        src2 = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            if (valid[k]) begin
                src1[k] = spec_map[rename_src1[k]];
                src2[k] = spec_map[rename_src2[k]];
                dst[k]  = free_q.pop_front();
                spec_map[rename_dst[k]] = dst[k];
                flight_areg.push_back(rename_dst[k]);
                flight_preg.push_back(dst[k]);
            end
        end
    endtask

    task automatic model_retire(input areg_t areg, input preg_t preg);
        free_q.push_back(ret_map[areg]);
        ret_map[areg] = preg;
    endtask

    task automatic model_recover();
        spec_map = ret_map;
        // squashed registers sit just past the tail, in allocation order
        while (flight_preg.size() > 0) begin
            free_q.push_front(flight_preg.pop_back());
        end
        flight_areg.delete();
    endtask

    `include "rename_checks.svh"

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        rename_valid = '0;
        rename_dst   = '0;
        rename_src1  = '0;
        rename_src2  = '0;
        retire_valid = '0;
        retire_areg  = '0;
        retire_preg  = '0;
        recover      = 1'b0;
        model_reset();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_reset_state();
        test_bypass();
        test_exhaustion();
        test_retire_reuse();
        test_recovery();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
+incdir+tests
hw/rename_pkg.sv
hw/free_list_if.sv
hw/free_list.sv
hw/spec_map_table.sv
hw/retire_map_table.sv
hw/rename_ctrl.sv
hw/rename_top.sv
tests/rename_tb.sv
